// ==== cp0_tlb_regs.sv ====
`timescale 1ns/10ps
`include "mmu_consts.svh"

module cp0_tlb_regs (
    input  logic                    aclk,
    input  logic                    arst_n,
    input  mmu_pkg::tlb_cmd_t       cmd,
    input  mmu_pkg::cp0_wr_t        cp0_wr,
    input  logic [4:0]              cp0_raddr,
    output logic [31:0]             cp0_rdata,
    input  logic                    probe_found,
    input  logic [`TLB_INDEX_W-1:0] probe_index,
    input  mmu_pkg::tlb_entry_t     rd_entry,
    output logic [`VPN2_W-1:0]      entryhi_vpn2,
    output logic [`ASID_W-1:0]      entryhi_asid,
    output mmu_pkg::tlb_entry_t     wr_entry,
    output logic [`TLB_INDEX_W-1:0] wr_index,
    output logic                    tlb_we
);
    import mmu_pkg::*;

    logic                    index_p;
    logic [`TLB_INDEX_W-1:0] index_val;
    logic [`TLB_INDEX_W-1:0] random_val;
    tlb_page_t               lo0_page;
    tlb_page_t               lo1_page;
    logic                    lo0_g;
    logic                    lo1_g;

    // EntryLo word layout
    function automatic logic [31:0] lo_word(input tlb_page_t pg, input logic g);
        return {6'b0, pg.pfn, pg.c, pg.d, pg.v, g};
    endfunction

    function automatic tlb_page_t lo_page(input logic [31:0] w);
        tlb_page_t pg;
        pg.pfn = w[25:6];
        pg.c   = w[5:3];
        pg.d   = w[2];
        pg.v   = w[1];
        return pg;
    endfunction

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            index_p      <= 1'b0;
            index_val    <= '0;
            random_val   <= `TLB_INDEX_W'(`TLB_ENTRIES - 1);
            entryhi_vpn2 <= '0;
            entryhi_asid <= '0;
            lo0_page     <= '0;
            lo1_page     <= '0;
            lo0_g        <= 1'b0;
            lo1_g        <= 1'b0;
        end else begin
            // free-running countdown that wraps 0 to the top entry
            if (random_val == '0) begin
                random_val <= `TLB_INDEX_W'(`TLB_ENTRIES - 1);
            end else begin
                random_val <= random_val - 1'b1;
            end

            // only writable fields land on mtc0 as P and Random are read only
            if (cp0_wr.we) begin
                case (cp0_wr.addr)
                    `CP0_INDEX: index_val <= cp0_wr.wdata[`TLB_INDEX_W-1:0];
                    `CP0_ENTRYLO0: begin
                        lo0_page <= lo_page(cp0_wr.wdata);
                        lo0_g    <= cp0_wr.wdata[0];
                    end
                    `CP0_ENTRYLO1: begin
                        lo1_page <= lo_page(cp0_wr.wdata);
                        lo1_g    <= cp0_wr.wdata[0];
                    end
                    `CP0_ENTRYHI: begin
                        entryhi_vpn2 <= cp0_wr.wdata[31:13];
                        entryhi_asid <= cp0_wr.wdata[`ASID_W-1:0];
                    end
                    default: ;
                endcase
            end

            // probe result keeps the index on a miss
            if (cmd.tlbp) begin
                index_p <= !probe_found;
                if (probe_found) begin
                    index_val <= probe_index;
                end
            end

            // tlbr copies g into both EntryLo g bits
            if (cmd.tlbr) begin
                entryhi_vpn2 <= rd_entry.vpn2;
                entryhi_asid <= rd_entry.asid;
                lo0_page     <= rd_entry.page_even;
                lo1_page     <= rd_entry.page_odd;
                lo0_g        <= rd_entry.g;
                lo1_g        <= rd_entry.g;
            end
        end
    end

    // staged entry for tlbwi/tlbwr
    assign wr_entry.vpn2      = entryhi_vpn2;
    assign wr_entry.asid      = entryhi_asid;
    assign wr_entry.g         = lo0_g & lo1_g;
    assign wr_entry.page_even = lo0_page;
    assign wr_entry.page_odd  = lo1_page;

    // Index also addresses the tlbr read
    assign wr_index = cmd.tlbwr ? random_val : index_val;
    assign tlb_we   = cmd.tlbwi | cmd.tlbwr;

    // mfc0 read mux
    always_comb begin
        case (cp0_raddr)
            `CP0_INDEX:    cp0_rdata = {index_p, {(31-`TLB_INDEX_W){1'b0}}, index_val};
            `CP0_RANDOM:   cp0_rdata = {{(32-`TLB_INDEX_W){1'b0}}, random_val};
            `CP0_ENTRYLO0: cp0_rdata = lo_word(lo0_page, lo0_g);
            `CP0_ENTRYLO1: cp0_rdata = lo_word(lo1_page, lo1_g);
            `CP0_ENTRYHI:  cp0_rdata = {entryhi_vpn2, {(13-`ASID_W){1'b0}}, entryhi_asid};
            default:       cp0_rdata = '0;
        endcase
    end

    a_one_cmd: assert property (
        @(posedge aclk) disable iff (!arst_n)
        $onehot0(cmd)
    ) else $error("cp0_tlb_regs: more than one tlb strobe in a cycle");

endmodule

// ==== mmu_consts.svh ====
`ifndef MMU_CONSTS_SVH
`define MMU_CONSTS_SVH

// joint tlb size
`define TLB_ENTRIES 16
`define TLB_INDEX_W 4

// virtual side of an entry
`define VPN2_W      19
`define ASID_W      8

// physical frame number of one page half
`define PFN_W       20

// cp0 register numbers as seen by mtc0/mfc0
`define CP0_INDEX    5'd0
`define CP0_RANDOM   5'd1
`define CP0_ENTRYLO0 5'd2
`define CP0_ENTRYLO1 5'd3
`define CP0_ENTRYHI  5'd10

`endif

// ==== mmu_pkg.sv ====
`include "mmu_consts.svh"

package mmu_pkg;

    // one half of an entry, even or odd page
    typedef struct packed {
        logic [`PFN_W-1:0] pfn;
        logic [2:0]        c;
        logic              d;
        logic              v;
    } tlb_page_t;

    typedef struct packed {
        logic [`VPN2_W-1:0] vpn2;
        logic [`ASID_W-1:0] asid;
        logic               g;
        tlb_page_t          page_even;
        tlb_page_t          page_odd;
    } tlb_entry_t;

    // result of one lookup port
    typedef struct packed {
        logic        found;
        logic        v;
        logic        d;
        logic [2:0]  c;
        logic [31:0] paddr;
    } tlb_xlat_t;

    // single-cycle operation strobes
    typedef struct packed {
        logic tlbwi;
        logic tlbwr;
        logic tlbp;
        logic tlbr;
    } tlb_cmd_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  addr;
        logic [31:0] wdata;
    } cp0_wr_t;

endpackage

// ==== mmu_tb.sv ====
`timescale 1ns/10ps
`include "mmu_consts.svh"

module mmu_tb;
    import mmu_pkg::*;

    localparam int          cycle_limit = 2000;
    localparam logic [31:0] lo_mask     = 32'h03ff_ffff;
    localparam logic [31:0] hi_mask     = 32'hffff_e0ff;
    // strobe order is tlbwi, tlbwr, tlbp, tlbr
    localparam tlb_cmd_t    do_tlbwi    = 4'b1000;
    localparam tlb_cmd_t    do_tlbwr    = 4'b0100;
    localparam tlb_cmd_t    do_tlbp     = 4'b0010;
    localparam tlb_cmd_t    do_tlbr     = 4'b0001;

    logic        aclk;
    logic        arst_n;
    logic [31:0] inst_vaddr;
    logic [31:0] data_vaddr;
    tlb_cmd_t    cmd;
    cp0_wr_t     cp0_wr;
    logic [4:0]  cp0_raddr;
    tlb_xlat_t   inst_xlat;
    tlb_xlat_t   data_xlat;
    logic [31:0] cp0_rdata;

    // reference registers and entries in mfc0 word layout
    logic        m_p;
    logic [3:0]  m_index;
    logic [3:0]  m_random;
    logic [31:0] m_hi;
    logic [31:0] m_lo0;
    logic [31:0] m_lo1;
    logic [31:0] m_ent_hi  [16];
    logic [31:0] m_ent_lo0 [16];
    logic [31:0] m_ent_lo1 [16];

    logic [31:0] exp_rdata;
    tlb_xlat_t   exp_inst;
    tlb_xlat_t   exp_data;
    logic        chk_rd;
    logic        chk_xlat;
    string       test_name;
    int          errors;
    int          cycles;
    logic [31:0] lfsr_state;

    tb_clock u_clock (.aclk(aclk), .arst_n(arst_n));

    mmu_top DUT (.*);

    // Random counts down every cycle and wraps 0 to 15
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            m_random <= 4'd15;
        end else begin
            m_random <= (m_random == 4'd0) ? 4'd15 : m_random - 4'd1;
        end
    end

    always_comb begin
        case (cp0_raddr)
            `CP0_INDEX:    exp_rdata = {m_p, 27'b0, m_index};
            `CP0_RANDOM:   exp_rdata = {28'b0, m_random};
            `CP0_ENTRYLO0: exp_rdata = m_lo0;
            `CP0_ENTRYLO1: exp_rdata = m_lo1;
            `CP0_ENTRYHI:  exp_rdata = m_hi;
            default:       exp_rdata = '0;
        endcase
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v          = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic tlb_xlat_t expected_xlat(input int idx, input logic [31:0] va,
                                                input logic hit);
        logic [31:0] lo;
        tlb_xlat_t   x;
        lo      = va[12] ? m_ent_lo1[idx] : m_ent_lo0[idx];
        x.found = hit;
        x.v     = lo[1];
        x.d     = lo[2];
        x.c     = lo[5:3];
        x.paddr = {lo[25:6], va[11:0]};
        return x;
    endfunction

    // only found is defined on a miss
    function automatic logic xlat_matches(input tlb_xlat_t act, input tlb_xlat_t want);
        return want.found ? (act == want) : !act.found;
    endfunction

    task automatic write_cp0(input logic [4:0] addr, input logic [31:0] data);
        cp0_wr = '{we: 1'b1, addr: addr, wdata: data};
        @(negedge aclk);
        cp0_wr.we = 1'b0;
        case (addr)
            `CP0_INDEX:    m_index = data[3:0];
            `CP0_ENTRYLO0: m_lo0 = data & lo_mask;
            `CP0_ENTRYLO1: m_lo1 = data & lo_mask;
            `CP0_ENTRYHI:  m_hi = data & hi_mask;
            default: ;
        endcase
    endtask

    task automatic check_read(input logic [4:0] addr);
        cp0_raddr = addr;
        chk_rd    = 1'b1;
        @(negedge aclk);
        chk_rd = 1'b0;
    endtask

    task automatic load_entry_regs(input logic g0, input logic g1);
        logic [31:0] w;
        write_cp0(`CP0_ENTRYHI, random_bits(32));
        w = random_bits(25);
        write_cp0(`CP0_ENTRYLO0, {6'b0, w[24:0], g0});
        w = random_bits(25);
        write_cp0(`CP0_ENTRYLO1, {6'b0, w[24:0], g1});
    endtask

    // one strobe cycle before the reference takes the effect
    task automatic tlb_op(input tlb_cmd_t c, input logic hit, input int idx);
        int slot;
        slot = c.tlbwr ? int'(m_random) : int'(m_index);
        cmd  = c;
        @(negedge aclk);
        cmd = '0;
        if (c.tlbwi || c.tlbwr) begin
            m_ent_hi[slot]  = m_hi;
            m_ent_lo0[slot] = {m_lo0[31:1], m_lo0[0] & m_lo1[0]};
            m_ent_lo1[slot] = {m_lo1[31:1], m_lo0[0] & m_lo1[0]};
        end
        if (c.tlbp) begin
            m_p = !hit;
            if (hit) begin
                m_index = idx[3:0];
            end
        end
        if (c.tlbr) begin
            m_hi  = m_ent_hi[slot];
            m_lo0 = m_ent_lo0[slot];
            m_lo1 = m_ent_lo1[slot];
        end
    endtask

    // even page on one port and odd on the other and swapped on the second pass
    task automatic check_xlat(input int idx, input logic hit);
        logic [31:0] off;
        off = random_bits(24);
        for (int k = 0; k < 2; k++) begin
            inst_vaddr = {m_ent_hi[idx][31:13], k[0], off[11:0]};
            data_vaddr = {m_ent_hi[idx][31:13], !k[0], off[23:12]};
            exp_inst   = expected_xlat(idx, inst_vaddr, hit);
            exp_data   = expected_xlat(idx, data_vaddr, hit);
            chk_xlat   = 1'b1;
            @(negedge aclk);
        end
        chk_xlat = 1'b0;
    endtask

    a_rdata: assert property (@(posedge aclk) disable iff (!arst_n)
        chk_rd |-> cp0_rdata == exp_rdata)
        else begin
            errors++;
            $display("CHECK FAILED %s mfc0: expected %h actual %h",
                     test_name, $sampled(exp_rdata), $sampled(cp0_rdata));
        end

    a_inst_xlat: assert property (@(posedge aclk) disable iff (!arst_n)
        chk_xlat |-> xlat_matches(inst_xlat, exp_inst))
        else begin
            errors++;
            $display("CHECK FAILED %s fetch port: expected %h actual %h",
                     test_name, $sampled(exp_inst), $sampled(inst_xlat));
        end

    a_data_xlat: assert property (@(posedge aclk) disable iff (!arst_n)
        chk_xlat |-> xlat_matches(data_xlat, exp_data))
        else begin
            errors++;
            $display("CHECK FAILED %s data port: expected %h actual %h",
                     test_name, $sampled(exp_data), $sampled(data_xlat));
        end

    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge aclk);
            cycles++;
        end
        errors++;
        $display("run stopped, tests still busy after %0d cycles", cycle_limit);
        $display("errors counted: %0d", errors);
        $display("Test failed");
        $finish;
    end

    initial begin
        logic [31:0] w;
        logic [3:0]  r;
        inst_vaddr = '0;
        data_vaddr = '0;
        cmd        = '0;
        cp0_wr     = '0;
        cp0_raddr  = '0;
        chk_rd     = 1'b0;
        chk_xlat   = 1'b0;
        exp_inst   = '0;
        exp_data   = '0;
        m_p        = 1'b0;
        m_index    = '0;
        m_hi       = '0;
        m_lo0      = '0;
        m_lo1      = '0;
        for (int i = 0; i < 16; i++) begin
            m_ent_hi[i]  = '0;
            m_ent_lo0[i] = '0;
            m_ent_lo1[i] = '0;
        end
        errors     = 0;
        lfsr_state = 32'ha197;
        test_name  = "reset";
        wait (arst_n === 1'b1);

        test_name = "reset values";
        check_read(`CP0_RANDOM);
        check_read(`CP0_INDEX);
        check_read(`CP0_ENTRYLO0);
        check_read(`CP0_ENTRYLO1);
        check_read(`CP0_ENTRYHI);
        test_name = "random countdown";
        cp0_raddr = `CP0_RANDOM;
        chk_rd    = 1'b1;
        repeat (20) @(negedge aclk);
        chk_rd = 1'b0;

        test_name = "mtc0 masking";
        write_cp0(`CP0_ENTRYHI, random_bits(32));
        check_read(`CP0_ENTRYHI);
        write_cp0(`CP0_ENTRYLO0, random_bits(32));
        check_read(`CP0_ENTRYLO0);
        write_cp0(`CP0_ENTRYLO1, random_bits(32));
        check_read(`CP0_ENTRYLO1);
        write_cp0(`CP0_INDEX, random_bits(32));
        check_read(`CP0_INDEX);

        test_name = "translate asid match";
        write_cp0(`CP0_INDEX, 32'd6);
        load_entry_regs(1'b0, 1'b0);
        tlb_op(do_tlbwi, 1'b0, 0);
        check_xlat(6, 1'b1);
        test_name = "translate asid mismatch";
        write_cp0(`CP0_ENTRYHI, m_hi ^ 32'h1);
        check_xlat(6, 1'b0);
        test_name = "translate global";
        write_cp0(`CP0_INDEX, 32'd9);
        load_entry_regs(1'b1, 1'b1);
        tlb_op(do_tlbwi, 1'b0, 0);
        write_cp0(`CP0_ENTRYHI, m_hi ^ 32'h5a);
        check_xlat(9, 1'b1);

        test_name = "tlbp hit";
        write_cp0(`CP0_ENTRYHI, m_ent_hi[6]);
        tlb_op(do_tlbp, 1'b1, 6);
        check_read(`CP0_INDEX);
        test_name = "tlbp miss";
        write_cp0(`CP0_ENTRYHI, random_bits(32));
        tlb_op(do_tlbp, 1'b0, 0);
        check_read(`CP0_INDEX);

        test_name = "tlbr readback";
        for (int i = 2; i < 6; i++) begin
            write_cp0(`CP0_INDEX, 32'(i));
            w = random_bits(2);
            load_entry_regs(w[0], w[1]);
            tlb_op(do_tlbwi, 1'b0, 0);
        end
        write_cp0(`CP0_INDEX, 32'd4);
        tlb_op(do_tlbr, 1'b0, 0);
        check_read(`CP0_ENTRYHI);
        check_read(`CP0_ENTRYLO0);
        check_read(`CP0_ENTRYLO1);

        // Random is read in the same cycle as the tlbwr strobe
        test_name = "tlbwr at random";
        load_entry_regs(1'b0, 1'b1);
        cp0_raddr = `CP0_RANDOM;
        chk_rd    = 1'b1;
        r         = m_random;
        tlb_op(do_tlbwr, 1'b0, 0);
        chk_rd = 1'b0;
        tlb_op(do_tlbp, 1'b1, int'(r));
        check_read(`CP0_INDEX);
        check_xlat(int'(r), 1'b1);

        repeat (2) @(negedge aclk);
        $display("errors counted: %0d", errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== mmu_top.sv ====
`timescale 1ns/10ps
`include "mmu_consts.svh"

module mmu_top (
    input  logic               aclk,
    input  logic               arst_n,
    input  logic [31:0]        inst_vaddr,
    input  logic [31:0]        data_vaddr,
    input  mmu_pkg::tlb_cmd_t  cmd,
    input  mmu_pkg::cp0_wr_t   cp0_wr,
    input  logic [4:0]         cp0_raddr,
    output mmu_pkg::tlb_xlat_t inst_xlat,
    output mmu_pkg::tlb_xlat_t data_xlat,
    output logic [31:0]        cp0_rdata
);
    import mmu_pkg::*;

    tlb_entry_t              entries [`TLB_ENTRIES];
    tlb_entry_t              rd_entry;
    tlb_entry_t              wr_entry;
    tlb_xlat_t               probe_xlat;
    logic [`TLB_INDEX_W-1:0] probe_index;
    logic [`TLB_INDEX_W-1:0] tlb_index;
    logic                    tlb_we;
    logic [`VPN2_W-1:0]      entryhi_vpn2;
    logic [`ASID_W-1:0]      entryhi_asid;

    cp0_tlb_regs u_cp0 (
        .aclk         (aclk),
        .arst_n       (arst_n),
        .cmd          (cmd),
        .cp0_wr       (cp0_wr),
        .cp0_raddr    (cp0_raddr),
        .cp0_rdata    (cp0_rdata),
        .probe_found  (probe_xlat.found),
        .probe_index  (probe_index),
        .rd_entry     (rd_entry),
        .entryhi_vpn2 (entryhi_vpn2),
        .entryhi_asid (entryhi_asid),
        .wr_entry     (wr_entry),
        .wr_index     (tlb_index),
        .tlb_we       (tlb_we)
    );

    // tlbr reads at the same index that tlbwi writes
    tlb_entry_array u_array (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .we       (tlb_we),
        .wr_index (tlb_index),
        .wr_entry (wr_entry),
        .rd_index (tlb_index),
        .entries  (entries),
        .rd_entry (rd_entry)
    );

    tlb_lookup u_inst_lookup (
        .entries   (entries),
        .vaddr     (inst_vaddr),
        .asid      (entryhi_asid),
        .xlat      (inst_xlat),
        .hit_index ()
    );

    tlb_lookup u_data_lookup (
        .entries   (entries),
        .vaddr     (data_vaddr),
        .asid      (entryhi_asid),
        .xlat      (data_xlat),
        .hit_index ()
    );

    // tlbp searches with EntryHi
    tlb_lookup u_probe_lookup (
        .entries   (entries),
        .vaddr     ({entryhi_vpn2, 13'b0}),
        .asid      (entryhi_asid),
        .xlat      (probe_xlat),
        .hit_index (probe_index)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mmu_tb -f sources.f -o mmu_sim

# the log decides the result, the simulator status does not
./obj_dir/mmu_sim | tee sim.log

if grep -qx "Test passed" sim.log; then
    exit 0
fi
exit 1

// ==== sources.f ====
+incdir+.
mmu_pkg.sv
tlb_lookup.sv
tlb_entry_array.sv
cp0_tlb_regs.sv
mmu_top.sv
tb_clock.sv
mmu_tb.sv

// ==== tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock (
    output logic aclk,
    output logic arst_n
);
    localparam int half_period  = 4;
    localparam int reset_cycles = 8;

    initial begin
        aclk = 1'b0;
        forever #(half_period) aclk = ~aclk;
    end

    // release away from the rising edge
    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge aclk);
        @(negedge aclk);
        arst_n = 1'b1;
    end

endmodule

// ==== tlb_entry_array.sv ====
`timescale 1ns/10ps
`include "mmu_consts.svh"

module tlb_entry_array (
    input  logic                    aclk,
    input  logic                    arst_n,
    input  logic                    we,
    input  logic [`TLB_INDEX_W-1:0] wr_index,
    input  mmu_pkg::tlb_entry_t     wr_entry,
    input  logic [`TLB_INDEX_W-1:0] rd_index,
    output mmu_pkg::tlb_entry_t     entries [`TLB_ENTRIES],
    output mmu_pkg::tlb_entry_t     rd_entry
);

    // one write per cycle from tlbwi or tlbwr
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `TLB_ENTRIES; i++) begin
                entries[i] <= '0;
            end
        end else if (we) begin
            entries[wr_index] <= wr_entry;
        end
    end

    // read port for tlbr
    assign rd_entry = entries[rd_index];

    // write index comes from cp0 Index or Random
    a_wr_index_known: assert property (
        @(posedge aclk) disable iff (!arst_n)
        we |-> !$isunknown(wr_index)
    ) else $error("tlb_entry_array: write with unknown index");

endmodule

// ==== tlb_lookup.sv ====
`timescale 1ns/10ps
`include "mmu_consts.svh"

module tlb_lookup (
    input  mmu_pkg::tlb_entry_t     entries [`TLB_ENTRIES],
    input  logic [31:0]             vaddr,
    input  logic [`ASID_W-1:0]      asid,
    output mmu_pkg::tlb_xlat_t      xlat,
    output logic [`TLB_INDEX_W-1:0] hit_index
);
    import mmu_pkg::*;

    logic [`TLB_ENTRIES-1:0] match;
    logic [`TLB_ENTRIES-1:0] live_match;
    tlb_page_t               page;

    // vpn2 compare that ignores asid for global entries
    always_comb begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            match[i] = (entries[i].vpn2 == vaddr[31:13]) &&
                       (entries[i].g || (entries[i].asid == asid));
        end
    end

    // pick the hit entry and its even/odd half by bit 12
    always_comb begin
        hit_index = '0;
        page      = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (match[i]) begin
                hit_index = `TLB_INDEX_W'(i);
                page      = vaddr[12] ? entries[i].page_odd : entries[i].page_even;
            end
        end
    end

    assign xlat.found = |match;
    assign xlat.v     = page.v;
    assign xlat.d     = page.d;
    assign xlat.c     = page.c;
    assign xlat.paddr = {page.pfn, vaddr[11:0]};

    // matches that map the addressed page as valid
    always_comb begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            live_match[i] = match[i] &&
                            (vaddr[12] ? entries[i].page_odd.v : entries[i].page_even.v);
        end
    end

    // software must never leave two valid entries covering one page
    always_comb begin
        assert final ($isunknown(live_match) || $onehot0(live_match))
            else $error("tlb_lookup: several entries hit vpn2 %h", vaddr[31:13]);
    end

endmodule
